/* rtl/ctrl_defs.svh */
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Instruction field width (opcode and funct)
`define CTRL_FIELD_W 6

// Datapath select widths
`define CTRL_SEL2_W 2
`define CTRL_SEL3_W 3
`define CTRL_SEL4_W 4

// Fixed memory latencies, in cycles
`define CTRL_FETCH_WAIT 3
`define CTRL_MEM_WAIT 2
`define CTRL_VEC_WAIT 2

// Wait timer width
`define CTRL_WAIT_W 3

`endif

/* rtl/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_defs.svh"

package ctrl_pkg;

    typedef enum logic [4:0] {
        ST_INIT_SP, ST_FETCH_WAIT, ST_FETCH, ST_DECODE, ST_DISPATCH,
        ST_ALU, ST_ALU_WRITE, ST_SLT, ST_SLT_WRITE, ST_LUI,
        ST_MEM_ADDR, ST_MEM_READ, ST_LOAD_SELECT, ST_LOAD_WRITE, ST_STORE,
        ST_JUMP, ST_JAL, ST_LINK, ST_JR, ST_RTE,
        ST_EXC_VECTOR, ST_EXC_ENTER
    } ctrl_state_e;

    typedef enum logic [`CTRL_FIELD_W-1:0] {
        R_TYPE = 6'h00,
        J      = 6'h02,
        JAL    = 6'h03,
        ADDI   = 6'h08,
        ADDIU  = 6'h09,
        SLTI   = 6'h0a,
        LUI    = 6'h0f,
        LB     = 6'h20,
        LH     = 6'h21,
        LW     = 6'h23,
        SB     = 6'h28,
        SH     = 6'h29,
        SW     = 6'h2b
    } opcode_e;

    typedef enum logic [`CTRL_FIELD_W-1:0] {
        JR  = 6'h08,
        RTE = 6'h13,
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        SLT = 6'h2a
    } funct_e;

    // Also the MDR and store-merge select code
    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_BYTE = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        CAUSE_OPCODE   = 2'd0,
        CAUSE_OVERFLOW = 2'd1
    } exc_cause_e;

endpackage

`default_nettype wire

/* rtl/decode_if.sv */
`default_nettype none

`include "ctrl_defs.svh"

interface decode_if;
    ctrl_pkg::ctrl_state_e   entry_state;
    logic [`CTRL_SEL3_W-1:0] alu_op;   // 1 add, 2 sub, 3 and
    ctrl_pkg::mem_size_e     mem_size;
    logic                    is_store;
    logic                    trap_ov;
    logic                    use_imm;  // Immediate operand, rt destination

    modport decoder (output entry_state, alu_op, mem_size, is_store, trap_ov, use_imm);
    modport sequencer (input entry_state, mem_size, is_store, trap_ov);
    modport outputs (input alu_op, mem_size, use_imm);
endinterface

`default_nettype wire

/* rtl/instr_decoder.sv */
`default_nettype none

`include "ctrl_defs.svh"

module instr_decoder (
    input  wire logic [`CTRL_FIELD_W-1:0] opcode,
    input  wire logic [`CTRL_FIELD_W-1:0] funct,
    decode_if.decoder                     dec
);

    always_comb begin
        // Anything not listed below traps as an illegal opcode
        dec.entry_state = ctrl_pkg::ST_EXC_VECTOR;
        dec.alu_op      = 3'd0;
        dec.mem_size    = ctrl_pkg::SIZE_WORD;
        dec.is_store    = 1'b0;
        dec.trap_ov     = 1'b0;
        dec.use_imm     = 1'b0;

        case (opcode)
            ctrl_pkg::R_TYPE: begin
                case (funct)
                    ctrl_pkg::ADD: begin
                        dec.entry_state = ctrl_pkg::ST_ALU;
                        dec.alu_op      = 3'd1;
                        dec.trap_ov     = 1'b1;
                    end
                    ctrl_pkg::SUB: begin
                        dec.entry_state = ctrl_pkg::ST_ALU;
                        dec.alu_op      = 3'd2;
                        dec.trap_ov     = 1'b1;
                    end
                    ctrl_pkg::AND: begin
                        dec.entry_state = ctrl_pkg::ST_ALU;
                        dec.alu_op      = 3'd3;
                    end
                    ctrl_pkg::SLT: dec.entry_state = ctrl_pkg::ST_SLT;
                    ctrl_pkg::JR:  dec.entry_state = ctrl_pkg::ST_JR;
                    ctrl_pkg::RTE: dec.entry_state = ctrl_pkg::ST_RTE;
                    default: ;
                endcase
            end
            ctrl_pkg::ADDI, ctrl_pkg::ADDIU: begin
                dec.entry_state = ctrl_pkg::ST_ALU;
                dec.alu_op      = 3'd1;
                dec.use_imm     = 1'b1;
                dec.trap_ov     = (opcode == ctrl_pkg::ADDI); // addiu never traps
            end
            ctrl_pkg::SLTI: begin
                dec.entry_state = ctrl_pkg::ST_SLT;
                dec.use_imm     = 1'b1;
            end
            ctrl_pkg::LUI: begin
                dec.entry_state = ctrl_pkg::ST_LUI;
                dec.use_imm     = 1'b1;
            end
            ctrl_pkg::LW, ctrl_pkg::LH, ctrl_pkg::LB,
            ctrl_pkg::SW, ctrl_pkg::SH, ctrl_pkg::SB: begin
                dec.entry_state = ctrl_pkg::ST_MEM_ADDR;
                dec.use_imm     = 1'b1;
                dec.is_store    = opcode[3];
                if (opcode[1:0] == 2'b00)
                    dec.mem_size = ctrl_pkg::SIZE_BYTE;
                else if (opcode[1:0] == 2'b01)
                    dec.mem_size = ctrl_pkg::SIZE_HALF;
            end
            ctrl_pkg::J:   dec.entry_state = ctrl_pkg::ST_JUMP;
            ctrl_pkg::JAL: dec.entry_state = ctrl_pkg::ST_JAL;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/wait_timer.sv */
`default_nettype none

`include "ctrl_defs.svh"

module wait_timer (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   start,   // First cycle of the wait
    input  wire logic [`CTRL_WAIT_W-1:0] cycles,
    output logic                        done
);

    logic [`CTRL_WAIT_W-1:0] count; // Cycles left, including the current one

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= cycles - 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // A one-cycle wait finishes in its start cycle
    assign done = start ? (cycles == `CTRL_WAIT_W'(1)) : (count == `CTRL_WAIT_W'(1));

endmodule

`default_nettype wire

/* rtl/ctrl_sequencer.sv */
`default_nettype none

`include "ctrl_defs.svh"

module ctrl_sequencer (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    ov,
    decode_if.sequencer                  dec,
    output logic                         wait_start,
    output logic [`CTRL_WAIT_W-1:0]      wait_cycles,
    input  wire logic                    wait_done,
    output ctrl_pkg::ctrl_state_e        state,
    output ctrl_pkg::exc_cause_e         cause
);

    ctrl_pkg::ctrl_state_e next_state;
    logic                  enter_wait;
    logic                  trap;

    assign trap = ov && dec.trap_ov;

    always_comb begin
        next_state = state;
        case (state)
            ctrl_pkg::ST_INIT_SP:     next_state = ctrl_pkg::ST_FETCH_WAIT;
            ctrl_pkg::ST_FETCH_WAIT: begin
                if (wait_done)
                    next_state = ctrl_pkg::ST_FETCH;
            end
            ctrl_pkg::ST_FETCH:       next_state = ctrl_pkg::ST_DECODE;
            ctrl_pkg::ST_DECODE:      next_state = ctrl_pkg::ST_DISPATCH;
            ctrl_pkg::ST_DISPATCH:    next_state = dec.entry_state;
            ctrl_pkg::ST_ALU: begin
                next_state = trap ? ctrl_pkg::ST_EXC_VECTOR : ctrl_pkg::ST_ALU_WRITE;
            end
            ctrl_pkg::ST_SLT:         next_state = ctrl_pkg::ST_SLT_WRITE;
            ctrl_pkg::ST_MEM_ADDR: begin
                // Word stores skip the read, partial stores merge into the old word
                if (dec.is_store && dec.mem_size == ctrl_pkg::SIZE_WORD)
                    next_state = ctrl_pkg::ST_STORE;
                else
                    next_state = ctrl_pkg::ST_MEM_READ;
            end
            ctrl_pkg::ST_MEM_READ: begin
                if (wait_done)
                    next_state = dec.is_store ? ctrl_pkg::ST_STORE : ctrl_pkg::ST_LOAD_SELECT;
            end
            ctrl_pkg::ST_LOAD_SELECT: next_state = ctrl_pkg::ST_LOAD_WRITE;
            ctrl_pkg::ST_JAL:         next_state = ctrl_pkg::ST_LINK;
            ctrl_pkg::ST_EXC_VECTOR: begin
                if (wait_done)
                    next_state = ctrl_pkg::ST_EXC_ENTER;
            end
            default:                  next_state = ctrl_pkg::ST_FETCH_WAIT; // Last step
        endcase
    end

    assign enter_wait = (next_state != state) &&
                        (next_state == ctrl_pkg::ST_FETCH_WAIT ||
                         next_state == ctrl_pkg::ST_MEM_READ ||
                         next_state == ctrl_pkg::ST_EXC_VECTOR);

    // Length of the wait that is running now
    always_comb begin
        case (state)
            ctrl_pkg::ST_FETCH_WAIT: wait_cycles = `CTRL_WAIT_W'(`CTRL_FETCH_WAIT);
            ctrl_pkg::ST_MEM_READ:   wait_cycles = `CTRL_WAIT_W'(`CTRL_MEM_WAIT);
            default:                 wait_cycles = `CTRL_WAIT_W'(`CTRL_VEC_WAIT);
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ctrl_pkg::ST_INIT_SP;
            wait_start <= 1'b0;
            cause      <= ctrl_pkg::CAUSE_OPCODE;
        end else begin
            state      <= next_state;
            wait_start <= enter_wait; // High in the first wait cycle
            if (state == ctrl_pkg::ST_DISPATCH &&
                dec.entry_state == ctrl_pkg::ST_EXC_VECTOR)
                cause <= ctrl_pkg::CAUSE_OPCODE;
            else if (state == ctrl_pkg::ST_ALU && trap)
                cause <= ctrl_pkg::CAUSE_OVERFLOW;
        end
    end

endmodule

`default_nettype wire

/* rtl/ctrl_outputs.sv */
`default_nettype none

`include "ctrl_defs.svh"

module ctrl_outputs (
    input  wire ctrl_pkg::ctrl_state_e state,
    input  wire ctrl_pkg::exc_cause_e  cause,
    input  wire logic               lt,
    decode_if.outputs               dec,
    output logic                    pc_write,
    output logic                    branch,
    output logic                    mem_wr,
    output logic                    ir_write,
    output logic                    a_write,
    output logic                    b_write,
    output logic                    alu_reg_write,
    output logic                    epc_write,
    output logic                    reg_write,
    output logic [`CTRL_SEL2_W-1:0] reg_dst,
    output logic [`CTRL_SEL2_W-1:0] except,
    output logic [`CTRL_SEL2_W-1:0] mem_to_mdr,
    output logic [`CTRL_SEL2_W-1:0] b_to_c,
    output logic [`CTRL_SEL2_W-1:0] alu_src_a,
    output logic [`CTRL_SEL3_W-1:0] i_or_d,
    output logic [`CTRL_SEL3_W-1:0] alu_src_b,
    output logic [`CTRL_SEL3_W-1:0] alu_op,
    output logic [`CTRL_SEL3_W-1:0] pc_src,
    output logic [`CTRL_SEL4_W-1:0] mem_to_reg
);

    logic [`CTRL_SEL2_W-1:0] dst_sel;  // rd for R-type, rt for immediate forms
    logic [`CTRL_SEL3_W-1:0] opb_sel;

    assign dst_sel = dec.use_imm ? 2'd0 : 2'd1;
    assign opb_sel = dec.use_imm ? 3'd2 : 3'd0;

    always_comb begin
        pc_write      = 1'b0;
        branch        = 1'b0;
        mem_wr        = 1'b0;
        ir_write      = 1'b0;
        a_write       = 1'b0;
        b_write       = 1'b0;
        alu_reg_write = 1'b0;
        epc_write     = 1'b0;
        reg_write     = 1'b0;
        reg_dst       = 2'd0;
        except        = 2'd0;
        mem_to_mdr    = 2'd0;
        b_to_c        = 2'd0;
        alu_src_a     = 2'd0;
        i_or_d        = 3'd0;
        alu_src_b     = 3'd0;
        alu_op        = 3'd0;
        pc_src        = 3'd0;
        mem_to_reg    = 4'd0;

        case (state)
            ctrl_pkg::ST_INIT_SP: begin // Stack top into sp
                reg_write  = 1'b1;
                reg_dst    = 2'd2;
                mem_to_reg = 4'd4;
            end
            ctrl_pkg::ST_FETCH_WAIT: begin
                alu_src_b = 3'd1;
                alu_op    = 3'd1;   // PC + 4
            end
            ctrl_pkg::ST_FETCH: begin
                pc_write  = 1'b1;
                ir_write  = 1'b1;
                alu_src_b = 3'd1;
                alu_op    = 3'd1;
            end
            ctrl_pkg::ST_DECODE: begin
                a_write   = 1'b1;
                b_write   = 1'b1;
                alu_src_b = 3'd1;
                alu_op    = 3'd1;
            end
            ctrl_pkg::ST_ALU: begin
                alu_src_a     = 2'd1;
                alu_src_b     = opb_sel;
                alu_op        = dec.alu_op;
                alu_reg_write = 1'b1;
            end
            ctrl_pkg::ST_ALU_WRITE: begin
                reg_write = 1'b1;
                reg_dst   = dst_sel;
            end
            ctrl_pkg::ST_SLT: begin
                alu_src_a = 2'd1;
                alu_src_b = opb_sel;
            end
            ctrl_pkg::ST_SLT_WRITE: begin
                alu_op     = 3'd7;  // Compare
                reg_write  = 1'b1;
                reg_dst    = dst_sel;
                mem_to_reg = lt ? 4'd6 : 4'd5;
            end
            ctrl_pkg::ST_LUI: begin
                reg_write  = 1'b1;
                mem_to_reg = 4'd8;
            end
            ctrl_pkg::ST_MEM_ADDR: begin
                alu_src_a     = 2'd1;
                alu_src_b     = 3'd2;
                alu_op        = 3'd1;
                alu_reg_write = 1'b1;
            end
            ctrl_pkg::ST_MEM_READ:    i_or_d     = 3'd1;
            ctrl_pkg::ST_LOAD_SELECT: mem_to_mdr = dec.mem_size;
            ctrl_pkg::ST_LOAD_WRITE: begin
                reg_write  = 1'b1;
                mem_to_reg = 4'd1;
            end
            ctrl_pkg::ST_STORE: begin
                mem_wr = 1'b1;
                i_or_d = 3'd1;
                b_to_c = dec.mem_size;
            end
            ctrl_pkg::ST_JUMP: begin
                pc_write = 1'b1;
                branch   = 1'b1;
                pc_src   = 3'd2;
            end
            ctrl_pkg::ST_JAL:  alu_reg_write = 1'b1; // Return address
            ctrl_pkg::ST_LINK: begin
                reg_write = 1'b1;
                reg_dst   = 2'd3;
                pc_write  = 1'b1;
                branch    = 1'b1;
                pc_src    = 3'd2;
            end
            ctrl_pkg::ST_JR: begin
                alu_src_a = 2'd1;
                pc_write  = 1'b1;
                branch    = 1'b1;
            end
            ctrl_pkg::ST_RTE: begin
                pc_write = 1'b1;
                pc_src   = 3'd4; // From EPC
            end
            ctrl_pkg::ST_EXC_VECTOR: begin
                except    = cause;
                i_or_d    = 3'd2;
                alu_src_b = 3'd1;
                alu_op    = 3'd2;   // PC - 4 for EPC
            end
            ctrl_pkg::ST_EXC_ENTER: begin
                epc_write = 1'b1;
                pc_write  = 1'b1;
                pc_src    = 3'd3;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/control_unit.sv */
`default_nettype none

`include "ctrl_defs.svh"

module control_unit (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     ov,
    input  wire logic                     lt,
    input  wire logic [`CTRL_FIELD_W-1:0] opcode,
    input  wire logic [`CTRL_FIELD_W-1:0] funct,
    output logic                          pc_write,
    output logic                          branch,
    output logic                          mem_wr,
    output logic                          ir_write,
    output logic                          a_write,
    output logic                          b_write,
    output logic                          alu_reg_write,
    output logic                          epc_write,
    output logic                          reg_write,
    output logic [`CTRL_SEL2_W-1:0]       reg_dst,
    output logic [`CTRL_SEL2_W-1:0]       except,
    output logic [`CTRL_SEL2_W-1:0]       mem_to_mdr,
    output logic [`CTRL_SEL2_W-1:0]       b_to_c,
    output logic [`CTRL_SEL2_W-1:0]       alu_src_a,
    output logic [`CTRL_SEL3_W-1:0]       i_or_d,
    output logic [`CTRL_SEL3_W-1:0]       alu_src_b,
    output logic [`CTRL_SEL3_W-1:0]       alu_op,
    output logic [`CTRL_SEL3_W-1:0]       pc_src,
    output logic [`CTRL_SEL4_W-1:0]       mem_to_reg
);

    ctrl_pkg::ctrl_state_e   state;
    ctrl_pkg::exc_cause_e    cause;
    logic                    wait_start;
    logic [`CTRL_WAIT_W-1:0] wait_cycles;
    logic                    wait_done;

    decode_if dec ();

    instr_decoder i_decoder (
        .opcode (opcode),
        .funct  (funct),
        .dec    (dec.decoder)
    );

    wait_timer i_timer (
        .clk    (clk),
        .reset  (reset),
        .start  (wait_start),
        .cycles (wait_cycles),
        .done   (wait_done)
    );

    ctrl_sequencer i_sequencer (
        .clk         (clk),
        .reset       (reset),
        .ov          (ov),
        .dec         (dec.sequencer),
        .wait_start  (wait_start),
        .wait_cycles (wait_cycles),
        .wait_done   (wait_done),
        .state       (state),
        .cause       (cause)
    );

    ctrl_outputs i_outputs (
        .state         (state),
        .cause         (cause),
        .lt            (lt),
        .dec           (dec.outputs),
        .pc_write      (pc_write),
        .branch        (branch),
        .mem_wr        (mem_wr),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .alu_reg_write (alu_reg_write),
        .epc_write     (epc_write),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .except        (except),
        .mem_to_mdr    (mem_to_mdr),
        .b_to_c        (b_to_c),
        .alu_src_a     (alu_src_a),
        .i_or_d        (i_or_d),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src),
        .mem_to_reg    (mem_to_reg)
    );

endmodule

`default_nettype wire

/* verif/control_unit_tb.sv */
`default_nettype none

`include "ctrl_defs.svh"

module control_unit_tb;

    localparam int NUM_ROWS = 28;
    localparam int TIMEOUT  = 40;   // Cycles allowed per wait

    typedef struct packed {
        logic [`CTRL_FIELD_W-1:0] opcode;
        logic [`CTRL_FIELD_W-1:0] funct;
        logic                     ov;
        logic                     lt;
        logic [7:0]               cycles;
        logic [3:0]               reg_writes;
        logic [1:0]               reg_dst;
        logic                     chk_m2r;     // Compare mem_to_reg at the write
        logic [3:0]               mem_to_reg;
        logic [3:0]               mem_wrs;
        logic [3:0]               epc_writes;
        logic [1:0]               except;
        logic [1:0]               mem_to_mdr;
        logic [1:0]               b_to_c;
    } row_t;

    logic                     clk;
    logic                     reset;
    logic                     ov;
    logic                     lt;
    logic [`CTRL_FIELD_W-1:0] opcode;
    logic [`CTRL_FIELD_W-1:0] funct;
    logic                     pc_write;
    logic                     branch;
    logic                     mem_wr;
    logic                     ir_write;
    logic                     a_write;
    logic                     b_write;
    logic                     alu_reg_write;
    logic                     epc_write;
    logic                     reg_write;
    logic [`CTRL_SEL2_W-1:0]  reg_dst;
    logic [`CTRL_SEL2_W-1:0]  except;
    logic [`CTRL_SEL2_W-1:0]  mem_to_mdr;
    logic [`CTRL_SEL2_W-1:0]  b_to_c;
    logic [`CTRL_SEL2_W-1:0]  alu_src_a;
    logic [`CTRL_SEL3_W-1:0]  i_or_d;
    logic [`CTRL_SEL3_W-1:0]  alu_src_b;
    logic [`CTRL_SEL3_W-1:0]  alu_op;
    logic [`CTRL_SEL3_W-1:0]  pc_src;
    logic [`CTRL_SEL4_W-1:0]  mem_to_reg;

    row_t  rows [NUM_ROWS];
    string names [NUM_ROWS];
    int    errors;
    int    tests_run;
    int    tests_failed;
    bit    timed_out;

    control_unit i_dut (
        .clk           (clk),
        .reset         (reset),
        .ov            (ov),
        .lt            (lt),
        .opcode        (opcode),
        .funct         (funct),
        .pc_write      (pc_write),
        .branch        (branch),
        .mem_wr        (mem_wr),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .alu_reg_write (alu_reg_write),
        .epc_write     (epc_write),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .except        (except),
        .mem_to_mdr    (mem_to_mdr),
        .b_to_c        (b_to_c),
        .alu_src_a     (alu_src_a),
        .i_or_d        (i_or_d),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src),
        .mem_to_reg    (mem_to_reg)
    );

    always #2 clk = ~clk;

    task automatic set_row(input int idx, input string name, input logic [5:0] op,
                           input logic [5:0] fn, input logic ovf, input logic ltf,
                           input int cyc, input int nrw, input int dst, input int chk,
                           input int m2r, input int nwr, input int nepc, input int exc,
                           input int mdr, input int btc);
        names[idx]             = name;
        rows[idx].opcode       = op;
        rows[idx].funct        = fn;
        rows[idx].ov           = ovf;
        rows[idx].lt           = ltf;
        rows[idx].cycles       = cyc;
        rows[idx].reg_writes   = nrw;
        rows[idx].reg_dst      = dst;
        rows[idx].chk_m2r      = chk;
        rows[idx].mem_to_reg   = m2r;
        rows[idx].mem_wrs      = nwr;
        rows[idx].epc_writes   = nepc;
        rows[idx].except       = exc;
        rows[idx].mem_to_mdr   = mdr;
        rows[idx].b_to_c       = btc;
    endtask

    // Standard MIPS encodings for opcode and funct
    task automatic fill_table();
        // idx  name        op     funct  ov lt  cyc rw dst chk m2r wr epc exc mdr b2c
        set_row(0,  "add",      6'h00, 6'h20, 0, 0,  8, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        set_row(1,  "sub",      6'h00, 6'h22, 0, 0,  8, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        set_row(2,  "and",      6'h00, 6'h24, 0, 0,  8, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        set_row(3,  "addi",     6'h08, 6'h00, 0, 0,  8, 1, 0, 1, 0, 0, 0, 0, 0, 0);
        set_row(4,  "addiu",    6'h09, 6'h00, 0, 0,  8, 1, 0, 1, 0, 0, 0, 0, 0, 0);
        set_row(5,  "slt_lt0",  6'h00, 6'h2a, 0, 0,  8, 1, 1, 1, 5, 0, 0, 0, 0, 0);
        set_row(6,  "slt_lt1",  6'h00, 6'h2a, 0, 1,  8, 1, 1, 1, 6, 0, 0, 0, 0, 0);
        set_row(7,  "slti_lt0", 6'h0a, 6'h00, 0, 0,  8, 1, 0, 1, 5, 0, 0, 0, 0, 0);
        set_row(8,  "slti_lt1", 6'h0a, 6'h00, 0, 1,  8, 1, 0, 1, 6, 0, 0, 0, 0, 0);
        set_row(9,  "lui",      6'h0f, 6'h00, 0, 0,  7, 1, 0, 0, 0, 0, 0, 0, 0, 0);
        set_row(10, "lw",       6'h23, 6'h00, 0, 0, 11, 1, 0, 1, 1, 0, 0, 0, 0, 0);
        set_row(11, "lh",       6'h21, 6'h00, 0, 0, 11, 1, 0, 1, 1, 0, 0, 0, 1, 0);
        set_row(12, "lb",       6'h20, 6'h00, 0, 0, 11, 1, 0, 1, 1, 0, 0, 0, 2, 0);
        set_row(13, "sw",       6'h2b, 6'h00, 0, 0,  8, 0, 0, 0, 0, 1, 0, 0, 0, 0);
        set_row(14, "sh",       6'h29, 6'h00, 0, 0, 10, 0, 0, 0, 0, 1, 0, 0, 0, 1);
        set_row(15, "sb",       6'h28, 6'h00, 0, 0, 10, 0, 0, 0, 0, 1, 0, 0, 0, 2);
        set_row(16, "j",        6'h02, 6'h00, 0, 0,  7, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        set_row(17, "jr",       6'h00, 6'h08, 0, 0,  7, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        set_row(18, "rte",      6'h00, 6'h13, 0, 0,  7, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        set_row(19, "jal",      6'h03, 6'h00, 0, 0,  8, 1, 3, 0, 0, 0, 0, 0, 0, 0);
        set_row(20, "add_ov",   6'h00, 6'h20, 1, 0, 10, 0, 0, 0, 0, 0, 1, 1, 0, 0);
        set_row(21, "illegal",  6'h3f, 6'h00, 0, 0,  9, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        set_row(22, "sub_ov",   6'h00, 6'h22, 1, 0, 10, 0, 0, 0, 0, 0, 1, 1, 0, 0);
        set_row(23, "addi_ov",  6'h08, 6'h00, 1, 0, 10, 0, 0, 0, 0, 0, 1, 1, 0, 0);
        set_row(24, "addiu_ov", 6'h09, 6'h00, 1, 0,  8, 1, 0, 1, 0, 0, 0, 0, 0, 0);
        set_row(25, "and_ov",   6'h00, 6'h24, 1, 0,  8, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        set_row(26, "bad_fn",   6'h00, 6'h3f, 0, 0,  9, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        set_row(27, "add_end",  6'h00, 6'h20, 0, 0,  8, 1, 1, 1, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic compare(input string name, input string sig, input logic [31:0] got,
                           input logic [31:0] exp, inout int row_errs);
        if (got !== exp) begin
            $display("mismatch %s in %s: got 0x%0h, expected 0x%0h", sig, name, got, exp);
            row_errs++;
        end
    endtask

    task automatic report_row(input string name, input int row_errs);
        tests_run++;
        errors += row_errs;
        if (row_errs == 0) begin
            $display("ok   %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, row_errs);
        end
    endtask

    task automatic check_reset();
        int pre;
        int writes;
        int row_errs;
        bit seen;
        pre      = 0;
        writes   = 0;
        row_errs = 0;
        seen     = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        compare("reset", "reg_write", reg_write, 1, row_errs);
        compare("reset", "reg_dst", reg_dst, 2, row_errs);
        compare("reset", "mem_to_reg", mem_to_reg, 4, row_errs);
        // Stack pointer write only
        compare("reset", "pc_write", pc_write, 0, row_errs);
        compare("reset", "branch", branch, 0, row_errs);
        compare("reset", "mem_wr", mem_wr, 0, row_errs);
        compare("reset", "ir_write", ir_write, 0, row_errs);
        compare("reset", "a_write", a_write, 0, row_errs);
        compare("reset", "b_write", b_write, 0, row_errs);
        compare("reset", "alu_reg_write", alu_reg_write, 0, row_errs);
        compare("reset", "epc_write", epc_write, 0, row_errs);
        compare("reset", "alu_src_a", alu_src_a, 0, row_errs);
        compare("reset", "alu_src_b", alu_src_b, 0, row_errs);
        compare("reset", "alu_op", alu_op, 0, row_errs);
        @(posedge clk);     // Fifth cycle in reset
        reset <= 1'b0;
        while (!seen && pre < TIMEOUT) begin
            @(negedge clk);
            if (ir_write) begin
                seen = 1'b1;
            end else begin
                pre++;
                if (reg_write)
                    writes++;
            end
        end
        if (!seen) begin
            $display("timeout: no instruction fetch within %0d cycles of reset", TIMEOUT);
            timed_out = 1'b1;
            row_errs++;
        end else begin
            compare("reset", "cycles before ir_write", pre, 4, row_errs);
            compare("reset", "reg_write count", writes, 1, row_errs);
        end
        report_row("reset", row_errs);
    endtask

    // Entered in the fetch cycle; returns in the next fetch cycle
    task automatic run_row(input int idx);
        row_t             r;
        int               cycles;
        int               n_rw;
        int               n_wr;
        int               n_epc;
        int               n_vec;
        int               row_errs;
        logic [1:0]       dst;
        logic [3:0]       m2r;
        logic [1:0]       exc;
        logic [1:0]       mdr;
        logic [1:0]       btc;
        bit               seen;
        r        = rows[idx];
        cycles   = 0;
        n_rw     = 0;
        n_wr     = 0;
        n_epc    = 0;
        n_vec    = 0;
        row_errs = 0;
        dst      = '0;
        m2r      = '0;
        exc      = '0;
        mdr      = '0;
        btc      = '0;
        seen     = 1'b0;
        @(posedge clk);
        opcode <= r.opcode;
        funct  <= r.funct;
        ov     <= r.ov;
        lt     <= r.lt;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (ir_write) begin
                seen = 1'b1;
                compare(names[idx], "pc_write", pc_write, 1, row_errs);
            end else begin
                if (cycles == 1) begin  // Decode step
                    compare(names[idx], "a_write", a_write, 1, row_errs);
                    compare(names[idx], "b_write", b_write, 1, row_errs);
                end
                if (reg_write) begin
                    n_rw++;
                    dst = reg_dst;
                    m2r = mem_to_reg;
                end
                if (mem_wr)
                    n_wr++;
                if (epc_write) begin
                    n_epc++;
                    compare(names[idx], "pc_src", pc_src, 3, row_errs);
                end
                if (i_or_d == 3'd2)
                    n_vec++;
                exc = exc | except;     // Each select is nonzero in one state only
                mdr = mdr | mem_to_mdr;
                btc = btc | b_to_c;
            end
        end
        if (!seen) begin
            $display("timeout: %s did not reach the next fetch within %0d cycles",
                     names[idx], TIMEOUT);
            timed_out = 1'b1;
            row_errs++;
        end else begin
            compare(names[idx], "cycles", cycles, r.cycles, row_errs);
            compare(names[idx], "reg_write count", n_rw, r.reg_writes, row_errs);
            compare(names[idx], "reg_dst", dst, r.reg_dst, row_errs);
            if (r.chk_m2r)
                compare(names[idx], "mem_to_reg", m2r, r.mem_to_reg, row_errs);
            compare(names[idx], "mem_wr count", n_wr, r.mem_wrs, row_errs);
            compare(names[idx], "epc_write count", n_epc, r.epc_writes, row_errs);
            compare(names[idx], "i_or_d vector cycles", n_vec,
                    r.epc_writes * `CTRL_VEC_WAIT, row_errs);
            compare(names[idx], "except", exc, r.except, row_errs);
            compare(names[idx], "mem_to_mdr", mdr, r.mem_to_mdr, row_errs);
            compare(names[idx], "b_to_c", btc, r.b_to_c, row_errs);
        end
        report_row(names[idx], row_errs);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ov           = 1'b0;
        lt           = 1'b0;
        opcode       = '0;
        funct        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        fill_table();
        check_reset();
        for (int i = 0; i < NUM_ROWS && !timed_out; i++)
            run_row(i);
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/decode_if.sv
rtl/instr_decoder.sv
rtl/wait_timer.sv
rtl/ctrl_sequencer.sv
rtl/ctrl_outputs.sv
rtl/control_unit.sv
verif/control_unit_tb.sv
